//--- src.f
design/mem_pkg.sv
design/mem_port_if.sv
design/sram_2p.sv
design/mem_port_ctrl.sv
design/mem_bank_array.sv
design/mem_read_return.sv
design/mem_1rw1w_top.sv
verif/tb_clk_gen.sv
verif/mem_1rw1w_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ns \
  -f src.f \
  --top-module mem_1rw1w_tb \
  -o mem_1rw1w_sim

output=$(./obj_dir/mem_1rw1w_sim)
echo "$output"

if grep -q "Testbench passed" <<< "$output"; then
  exit 0
else
  exit 1
fi

//--- verif/mem_1rw1w_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_1rw1w_tb;
  import mem_pkg::*;

  localparam int WIDTH   = 32;
  localparam int BITADDR = 10;
  localparam int NUMSROW = 128;
  localparam int RD_LAT  = 4; // sampling edge to rw_vld.

  typedef logic [BITADDR-1:0] addr_t;

  typedef struct packed {
    logic [WIDTH-1:0] data;
    addr_t            padr;
    int               due; // negedge count where rw_vld must be seen.
  } exp_t;

  logic             clk;
  logic             rst_n;
  logic             ready;
  logic             rw_read;
  logic             rw_write;
  addr_t            rw_addr;
  logic [WIDTH-1:0] rw_din;
  logic             rw_vld;
  logic [WIDTH-1:0] rw_dout;
  addr_t            rw_padr;
  logic             write;
  addr_t            wr_adr;
  logic [WIDTH-1:0] din;

  logic [WIDTH-1:0] ref_mem [addr_t]; // unwritten words read as zero.
  exp_t             exp_q [$];
  int               neg_cnt     = 0;
  int               err_cnt     = 0;
  int               mon_err_cnt = 0;
  int               timeout_cnt = 0;
  int               n_reads     = 0;
  int               n_resp      = 0;
  int               seed;

  tb_clk_gen u_clk (
    .clk  (clk),
    .rst_n(rst_n)
  );

  mem_1rw1w_top dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .ready   (ready),
    .rw_read (rw_read),
    .rw_write(rw_write),
    .rw_addr (rw_addr),
    .rw_din  (rw_din),
    .rw_vld  (rw_vld),
    .rw_dout (rw_dout),
    .rw_padr (rw_padr),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din)
  );

  function automatic logic [WIDTH-1:0] model_read(input addr_t a);
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    return '0;
  endfunction

  // address is {row, word, bank}, padr is {bank, row, word}.
  function automatic addr_t phys_addr(input addr_t a);
    return {a[1:0], a[9:3], a[2]};
  endfunction

  function automatic addr_t make_addr(input logic [1:0] bank, input logic [6:0] row,
                                      input logic word);
    return {row, word, bank};
  endfunction

  // one request cycle on both ports, mirrored into the model.
  task automatic drive_cycle(input logic rd, input logic rw_wr, input addr_t a,
                             input logic [WIDTH-1:0] a_din, input logic wr,
                             input addr_t w_a, input logic [WIDTH-1:0] w_din);
    exp_t e;
    @(posedge clk);
    rw_read  <= rd;
    rw_write <= rw_wr;
    rw_addr  <= a;
    rw_din   <= a_din;
    write    <= wr;
    wr_adr   <= w_a;
    din      <= w_din;
    if (rw_wr) begin
      ref_mem[a] = a_din;
    end else if (rd) begin
      e.data = model_read(a); // old data, before this cycle's writes.
      e.padr = phys_addr(a);
      e.due  = neg_cnt + 2 + RD_LAT; // sampled on the next edge.
      exp_q.push_back(e);
      n_reads++;
    end
    if (wr) begin
      ref_mem[w_a] = w_din; // write port lands last.
    end
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, '0, '0);
  endtask

  task automatic drain_reads();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 4 * RD_LAT) begin
      @(negedge clk);
      waited++;
    end
    assert (exp_q.size() == 0) else begin
      timeout_cnt++;
      $display("timed out waiting for %0d read responses", exp_q.size());
    end
  endtask

  // matches each rw_vld against the oldest outstanding read.
  function automatic void check_response();
    exp_t e;
    if (rw_vld === 1'b1) begin
      n_resp++;
      assert (exp_q.size() != 0) else begin
        mon_err_cnt++;
        $display("rw_vld was raised with no read outstanding at cycle %0d", neg_cnt);
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (e.due == neg_cnt) else begin
          mon_err_cnt++;
          $display("read of padr %h returned at cycle %0d instead of %0d", e.padr, neg_cnt,
                   e.due);
        end
        assert (rw_dout === e.data) else begin
          mon_err_cnt++;
          $display("** Error: rw_dout = %h, expected %h", rw_dout, e.data);
        end
        assert (rw_padr === e.padr) else begin
          mon_err_cnt++;
          $display("** Error: rw_padr = %h, expected %h", rw_padr, e.padr);
        end
      end
    end else if (exp_q.size() != 0) begin
      assert (exp_q[0].due > neg_cnt) else begin
        e = exp_q.pop_front();
        mon_err_cnt++;
        $display("read of padr %h got no rw_vld by cycle %0d", e.padr, neg_cnt);
      end
    end
  endfunction

  always @(negedge clk) begin
    neg_cnt = neg_cnt + 1;
    if (rst_n === 1'b1) begin
      check_response();
    end
  end

  task automatic check_init();
    int          waited;
    int          low_cnt;
    int          vld_seen;
    init_state_e st;
    waited   = 0;
    low_cnt  = 0;
    vld_seen = 0;
    while (rst_n !== 1'b1 && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    assert (rst_n === 1'b1) else begin
      timeout_cnt++;
      $display("reset was never released");
    end
    while (ready !== 1'b1 && low_cnt < 2 * NUMSROW) begin
      low_cnt++;
      @(posedge clk);
      rw_read <= (low_cnt == 2); // one read during the sweep.
      rw_addr <= 10'h0a5;
      @(negedge clk);
      if (low_cnt <= 12 && rw_vld === 1'b1) begin
        vld_seen++;
      end
    end
    assert (ready === 1'b1) else begin
      timeout_cnt++;
      $display("ready never rose after reset");
    end
    assert (low_cnt == NUMSROW) else begin
      err_cnt++;
      $display("** Error: ready low for %h cycles, expected %h", low_cnt, NUMSROW);
    end
    assert (vld_seen == 0) else begin
      err_cnt++;
      $display("** Error: rw_vld = 1 during init, expected 0");
    end
    st = dut0.u_ctrl.state;
    $display("init sweep done after %0d cycles, state %s", low_cnt, st.name());
    drive_cycle(1'b1, 1'b0, 10'h000, '0, 1'b0, '0, '0);
    drive_cycle(1'b1, 1'b0, 10'h001, '0, 1'b0, '0, '0);
    drive_cycle(1'b1, 1'b0, 10'h155, '0, 1'b0, '0, '0);
    drive_cycle(1'b1, 1'b0, 10'h3ff, '0, 1'b0, '0, '0);
    idle_cycle();
    drain_reads();
  endtask

  task automatic check_rw_readback();
    drive_cycle(1'b0, 1'b1, 10'h123, 32'hdead_beef, 1'b0, '0, '0);
    drive_cycle(1'b1, 1'b0, 10'h123, '0, 1'b0, '0, '0);
    drive_cycle(1'b0, 1'b1, 10'h2c6, 32'h0bad_f00d, 1'b0, '0, '0);
    drive_cycle(1'b1, 1'b0, 10'h2c6, '0, 1'b0, '0, '0);
    idle_cycle();
    drain_reads();
  endtask

  task automatic check_word_packing();
    addr_t w0;
    addr_t w1;
    w0 = make_addr(2'd2, 7'h2a, 1'b0);
    w1 = make_addr(2'd2, 7'h2a, 1'b1); // same bank and row.
    drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, w0, 32'h0a0a_5050);
    drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, w1, 32'hc3c3_1234);
    drive_cycle(1'b1, 1'b0, w0, '0, 1'b0, '0, '0);
    drive_cycle(1'b1, 1'b0, w1, '0, 1'b0, '0, '0);
    idle_cycle();
    drain_reads();
  endtask

  task automatic check_collisions();
    addr_t a;
    addr_t b;
    int    resp_before;
    a = make_addr(2'd1, 7'h33, 1'b1);
    b = make_addr(2'd3, 7'h07, 1'b0);
    drive_cycle(1'b0, 1'b1, a, 32'h1111_aaaa, 1'b1, a, 32'h2222_bbbb);
    drive_cycle(1'b1, 1'b0, a, '0, 1'b0, '0, '0);
    idle_cycle();
    drain_reads();
    drive_cycle(1'b1, 1'b0, a, '0, 1'b1, a, 32'h3333_cccc); // returns the old word.
    drive_cycle(1'b1, 1'b0, a, '0, 1'b0, '0, '0);
    idle_cycle();
    drain_reads();
    resp_before = n_resp;
    drive_cycle(1'b1, 1'b1, b, 32'h4444_dddd, 1'b0, '0, '0);
    idle_cycle();
    repeat (RD_LAT + 4) @(negedge clk);
    assert (n_resp == resp_before) else begin
      err_cnt++;
      $display("rw_read with rw_write produced a read response");
    end
    drive_cycle(1'b1, 1'b0, b, '0, 1'b0, '0, '0);
    idle_cycle();
    drain_reads();
  endtask

  task automatic check_random_stream();
    logic [31:0]      rnd;
    addr_t            a;
    addr_t            w_a;
    logic             rw_wr;
    logic             wr;
    logic [WIDTH-1:0] a_din;
    logic [WIDTH-1:0] w_din;
    int               reads0;
    int               resp0;
    reads0 = n_reads;
    resp0  = n_resp;
    for (int i = 0; i < 300; i++) begin
      rnd   = $random(seed);
      a     = {5'd0, rnd[4:0]}; // 32 words keep collisions frequent.
      rw_wr = (rnd[9:8] == 2'd0);
      wr    = rnd[12];
      w_a   = {5'd0, rnd[20:16]};
      a_din = $random(seed);
      w_din = $random(seed);
      drive_cycle(1'b1, rw_wr, a, a_din, wr, w_a, w_din);
    end
    idle_cycle();
    drain_reads();
    assert ((n_resp - resp0) == (n_reads - reads0)) else begin
      err_cnt++;
      $display("random stream gave %0d responses for %0d reads", n_resp - resp0,
               n_reads - reads0);
    end
  endtask

  initial begin
    seed = 38;
    rw_read  <= 1'b0;
    rw_write <= 1'b0;
    rw_addr  <= '0;
    rw_din   <= '0;
    write    <= 1'b0;
    wr_adr   <= '0;
    din      <= '0;
    check_init();
    check_rw_readback();
    check_word_packing();
    check_collisions();
    check_random_stream();
    $display("done: %0d errors, %0d response errors, %0d timeouts, %0d reads, %0d responses",
             err_cnt, mon_err_cnt, timeout_cnt, n_reads, n_resp);
    if (err_cnt == 0 && mon_err_cnt == 0 && timeout_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period.
  end

  initial begin
    rst_n <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1; // released on a rising edge.
  end

endmodule

`default_nettype wire

//--- design/mem_1rw1w_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_1rw1w_top #(
  parameter int WIDTH      = mem_pkg::DEF_WIDTH,
  parameter int NUMADDR    = mem_pkg::DEF_NUMADDR,
  parameter int NUMVBNK    = mem_pkg::DEF_NUMVBNK,
  parameter int NUMWRDS    = mem_pkg::DEF_NUMWRDS,
  parameter int SRAM_DELAY = mem_pkg::DEF_SRAM_DELAY,
  localparam int BITADDR   = $clog2(NUMADDR),
  localparam int BITPADR   = $clog2(NUMADDR), // bank, row and word bits.
  localparam int PHYWDTH   = NUMWRDS * WIDTH
) (
  input  logic               clk,
  input  logic               rst_n,
  output logic               ready,
  input  logic               rw_read,
  input  logic               rw_write,
  input  logic [BITADDR-1:0] rw_addr,
  input  logic [WIDTH-1:0]   rw_din,
  output logic               rw_vld,
  output logic [WIDTH-1:0]   rw_dout,
  output logic [BITPADR-1:0] rw_padr,
  input  logic               write,
  input  logic [BITADDR-1:0] wr_adr,
  input  logic [WIDTH-1:0]   din
);

  logic [NUMVBNK*PHYWDTH-1:0] bank_dout;

  mem_port_if #(.WIDTH(WIDTH), .NUMADDR(NUMADDR), .NUMVBNK(NUMVBNK), .NUMWRDS(NUMWRDS))
    port_a (); // rw port requests.
  mem_port_if #(.WIDTH(WIDTH), .NUMADDR(NUMADDR), .NUMVBNK(NUMVBNK), .NUMWRDS(NUMWRDS))
    port_b (); // write port requests and the init sweep.

  mem_port_ctrl #(
    .WIDTH  (WIDTH),
    .NUMADDR(NUMADDR),
    .NUMVBNK(NUMVBNK),
    .NUMWRDS(NUMWRDS)
  ) u_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .rw_read (rw_read),
    .rw_write(rw_write),
    .rw_addr (rw_addr),
    .rw_din  (rw_din),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .ready   (ready),
    .port_a  (port_a),
    .port_b  (port_b)
  );

  mem_bank_array #(
    .WIDTH     (WIDTH),
    .NUMADDR   (NUMADDR),
    .NUMVBNK   (NUMVBNK),
    .NUMWRDS   (NUMWRDS),
    .SRAM_DELAY(SRAM_DELAY)
  ) u_array (
    .clk      (clk),
    .rst_n    (rst_n),
    .ready    (ready),
    .port_a   (port_a),
    .port_b   (port_b),
    .bank_dout(bank_dout)
  );

  mem_read_return #(
    .WIDTH     (WIDTH),
    .NUMADDR   (NUMADDR),
    .NUMVBNK   (NUMVBNK),
    .NUMWRDS   (NUMWRDS),
    .SRAM_DELAY(SRAM_DELAY)
  ) u_ret (
    .clk      (clk),
    .rst_n    (rst_n),
    .port_a   (port_a),
    .bank_dout(bank_dout),
    .rw_vld   (rw_vld),
    .rw_dout  (rw_dout),
    .rw_padr  (rw_padr)
  );

endmodule

`default_nettype wire

//--- design/mem_read_return.sv
`timescale 1ns/1ns
`default_nettype none

module mem_read_return #(
  parameter int WIDTH      = mem_pkg::DEF_WIDTH,
  parameter int NUMADDR    = mem_pkg::DEF_NUMADDR,
  parameter int NUMVBNK    = mem_pkg::DEF_NUMVBNK,
  parameter int NUMWRDS    = mem_pkg::DEF_NUMWRDS,
  parameter int SRAM_DELAY = mem_pkg::DEF_SRAM_DELAY,
  localparam int PHYWDTH   = NUMWRDS * WIDTH,
  localparam int BITPADR   = $clog2(NUMADDR)
) (
  input  logic                       clk,
  input  logic                       rst_n,
  mem_port_if.tap                    port_a,
  input  logic [NUMVBNK*PHYWDTH-1:0] bank_dout,
  output logic                       rw_vld,
  output logic [WIDTH-1:0]           rw_dout,
  output logic [BITPADR-1:0]         rw_padr
);
  import mem_pkg::*;

  localparam int BITVBNK = $clog2(NUMVBNK);
  localparam int BITWRDS = $clog2(NUMWRDS);
  localparam int NUMSROW = NUMADDR / (NUMVBNK * NUMWRDS);
  localparam int BITSROW = $clog2(NUMSROW);
  localparam int RD_LAT  = SRAM_DELAY + 1; // bank access stage plus sram delay.

  logic [RD_LAT-1:0]  vld_pipe;
  logic [BITVBNK-1:0] bank_pipe [RD_LAT];
  logic [BITSROW-1:0] row_pipe [RD_LAT];
  logic [BITWRDS-1:0] word_pipe [RD_LAT];
  logic [PHYWDTH-1:0] sel_row;
  logic [WIDTH-1:0]   sel_word;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[RD_LAT-2:0], port_a.op == OP_READ};
    end
  end

  always_ff @(posedge clk) begin
    bank_pipe[0] <= port_a.bank;
    row_pipe[0]  <= port_a.row;
    word_pipe[0] <= port_a.word;
    for (int i = 1; i < RD_LAT; i++) begin
      bank_pipe[i] <= bank_pipe[i-1];
      row_pipe[i]  <= row_pipe[i-1];
      word_pipe[i] <= word_pipe[i-1];
    end
  end

  // pick the bank row, then the word slot within it.
  assign sel_row  = bank_dout[bank_pipe[RD_LAT-1]*PHYWDTH +: PHYWDTH];
  assign sel_word = sel_row[word_pipe[RD_LAT-1]*WIDTH +: WIDTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rw_vld <= 1'b0;
    end else begin
      rw_vld <= vld_pipe[RD_LAT-1];
    end
  end

  always_ff @(posedge clk) begin
    if (vld_pipe[RD_LAT-1]) begin
      rw_dout <= sel_word;
      rw_padr <= {bank_pipe[RD_LAT-1], row_pipe[RD_LAT-1], word_pipe[RD_LAT-1]};
    end
  end

endmodule

`default_nettype wire

//--- design/mem_bank_array.sv
`timescale 1ns/1ns
`default_nettype none

module mem_bank_array #(
  parameter int WIDTH      = mem_pkg::DEF_WIDTH,
  parameter int NUMADDR    = mem_pkg::DEF_NUMADDR,
  parameter int NUMVBNK    = mem_pkg::DEF_NUMVBNK,
  parameter int NUMWRDS    = mem_pkg::DEF_NUMWRDS,
  parameter int SRAM_DELAY = mem_pkg::DEF_SRAM_DELAY,
  localparam int PHYWDTH   = NUMWRDS * WIDTH
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       ready,
  mem_port_if.array                  port_a,
  mem_port_if.array                  port_b,
  output logic [NUMVBNK*PHYWDTH-1:0] bank_dout
);
  import mem_pkg::*;

  localparam int BITVBNK = $clog2(NUMVBNK);
  localparam int BITWRDS = $clog2(NUMWRDS);
  localparam int NUMSROW = NUMADDR / (NUMVBNK * NUMWRDS);

  logic               sweep;
  logic [PHYWDTH-1:0] row_din_a;
  logic [PHYWDTH-1:0] row_din_b;
  logic [PHYWDTH-1:0] bw_a;
  logic [PHYWDTH-1:0] bw_b;

  function automatic logic [PHYWDTH-1:0] word_mask(input logic [BITWRDS-1:0] word);
    logic [PHYWDTH-1:0] mask;
    mask = '0;
    mask[word*WIDTH +: WIDTH] = '1;
    return mask;
  endfunction

  // the last clear row is issued on the edge that raises ready,
  // so the broadcast follows ready one cycle late.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sweep <= 1'b1;
    end else begin
      sweep <= !ready;
    end
  end

  assign row_din_a = {NUMWRDS{port_a.din}};
  assign row_din_b = {NUMWRDS{port_b.din}};
  assign bw_a      = word_mask(port_a.word);
  assign bw_b      = sweep ? '1 : word_mask(port_b.word); // full row while clearing.

  for (genvar b = 0; b < NUMVBNK; b++) begin : g_bank
    logic sel_a;
    logic sel_b;

    assign sel_a = (port_a.bank == BITVBNK'(b));
    assign sel_b = sweep || (port_b.bank == BITVBNK'(b));

    sram_2p #(
      .PHYWDTH   (PHYWDTH),
      .NUMSROW   (NUMSROW),
      .SRAM_DELAY(SRAM_DELAY)
    ) u_sram (
      .clk    (clk),
      .rst_n  (rst_n),
      .read_a (sel_a && (port_a.op == OP_READ)),
      .write_a(sel_a && (port_a.op == OP_WRITE)),
      .addr_a (port_a.row),
      .din_a  (row_din_a),
      .bw_a   (bw_a),
      .read_b (1'b0), // port b is write only.
      .write_b(sel_b && (port_b.op == OP_WRITE)),
      .addr_b (port_b.row),
      .din_b  (row_din_b),
      .bw_b   (bw_b),
      .dout_a (bank_dout[b*PHYWDTH +: PHYWDTH])
    );
  end

endmodule

`default_nettype wire

//--- design/mem_port_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module mem_port_ctrl #(
  parameter int WIDTH   = mem_pkg::DEF_WIDTH,
  parameter int NUMADDR = mem_pkg::DEF_NUMADDR,
  parameter int NUMVBNK = mem_pkg::DEF_NUMVBNK,
  parameter int NUMWRDS = mem_pkg::DEF_NUMWRDS,
  localparam int BITADDR = $clog2(NUMADDR)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rw_read,
  input  logic               rw_write,
  input  logic [BITADDR-1:0] rw_addr,
  input  logic [WIDTH-1:0]   rw_din,
  input  logic               write,
  input  logic [BITADDR-1:0] wr_adr,
  input  logic [WIDTH-1:0]   din,
  output logic               ready,
  mem_port_if.ctrl           port_a,
  mem_port_if.ctrl           port_b
);
  import mem_pkg::*;

  localparam int BITVBNK = $clog2(NUMVBNK);
  localparam int BITWRDS = $clog2(NUMWRDS);
  localparam int NUMSROW = NUMADDR / (NUMVBNK * NUMWRDS);
  localparam int BITSROW = $clog2(NUMSROW);
  localparam int ROWLSB  = BITVBNK + BITWRDS; // row sits above bank and word.

  init_state_e        state;
  logic [BITSROW-1:0] init_row;
  logic               last_row;

  assign last_row = (init_row == BITSROW'(NUMSROW - 1));
  assign ready    = (state == INIT_DONE);

  // init sweep, one row per cycle.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= INIT_CLEAR;
      init_row <= '0;
    end else if (state == INIT_CLEAR) begin
      init_row <= init_row + 1'b1;
      if (last_row) begin
        state <= INIT_DONE;
      end
    end
  end

  // decoded ops, rw_write wins over rw_read.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      port_a.op <= OP_IDLE;
      port_b.op <= OP_IDLE;
    end else if (!ready) begin
      port_a.op <= OP_IDLE;  // user requests are dropped during init.
      port_b.op <= OP_WRITE; // clear write of the current row.
    end else begin
      port_a.op <= rw_write ? OP_WRITE : (rw_read ? OP_READ : OP_IDLE);
      port_b.op <= write ? OP_WRITE : OP_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    port_a.bank <= rw_addr[BITVBNK-1:0];
    port_a.word <= rw_addr[BITVBNK +: BITWRDS];
    port_a.row  <= rw_addr[ROWLSB +: BITSROW];
    port_a.din  <= rw_din;
  end

  always_ff @(posedge clk) begin
    if (!ready) begin
      // the array broadcasts these to every bank.
      port_b.bank <= '0;
      port_b.word <= '0;
      port_b.row  <= init_row;
      port_b.din  <= '0;
    end else begin
      port_b.bank <= wr_adr[BITVBNK-1:0];
      port_b.word <= wr_adr[BITVBNK +: BITWRDS];
      port_b.row  <= wr_adr[ROWLSB +: BITSROW];
      port_b.din  <= din;
    end
  end

endmodule

`default_nettype wire

//--- design/sram_2p.sv
`timescale 1ns/1ns
`default_nettype none

module sram_2p #(
  parameter int PHYWDTH    = mem_pkg::DEF_NUMWRDS * mem_pkg::DEF_WIDTH,
  parameter int NUMSROW    = mem_pkg::DEF_NUMADDR / (mem_pkg::DEF_NUMVBNK * mem_pkg::DEF_NUMWRDS),
  parameter int SRAM_DELAY = mem_pkg::DEF_SRAM_DELAY,
  localparam int BITSROW   = $clog2(NUMSROW)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               read_a,
  input  logic               write_a,
  input  logic [BITSROW-1:0] addr_a,
  input  logic [PHYWDTH-1:0] din_a,
  input  logic [PHYWDTH-1:0] bw_a,
  input  logic               read_b,
  input  logic               write_b,
  input  logic [BITSROW-1:0] addr_b,
  input  logic [PHYWDTH-1:0] din_b,
  input  logic [PHYWDTH-1:0] bw_b,
  output logic [PHYWDTH-1:0] dout_a
);

  logic [PHYWDTH-1:0] mem [NUMSROW];
  logic [PHYWDTH-1:0] rd_pipe [SRAM_DELAY+1]; // array access stage plus the delay.
  logic [BITSROW-1:0] rd_addr;
  logic [PHYWDTH-1:0] row_a;
  logic [PHYWDTH-1:0] base_b;
  logic [PHYWDTH-1:0] row_b;

  assign rd_addr = read_a ? addr_a : addr_b; // one shared read data path.
  assign row_a   = (mem[addr_a] & ~bw_a) | (din_a & bw_a);
  assign base_b  = (write_a && (addr_a == addr_b)) ? row_a : mem[addr_b];
  assign row_b   = (base_b & ~bw_b) | (din_b & bw_b); // b lands on top of a.

  always_ff @(posedge clk) begin
    if (write_a) begin
      mem[addr_a] <= row_a;
    end
    if (write_b) begin
      mem[addr_b] <= row_b;
    end
  end

  // reads see the row as it was before this edge's writes.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i <= SRAM_DELAY; i++) begin
        rd_pipe[i] <= '0;
      end
    end else begin
      if (read_a || read_b) begin
        rd_pipe[0] <= mem[rd_addr];
      end
      for (int i = 1; i <= SRAM_DELAY; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
    end
  end

  assign dout_a = rd_pipe[SRAM_DELAY];

endmodule

`default_nettype wire

//--- design/mem_port_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_port_if #(
  parameter int WIDTH   = mem_pkg::DEF_WIDTH,
  parameter int NUMADDR = mem_pkg::DEF_NUMADDR,
  parameter int NUMVBNK = mem_pkg::DEF_NUMVBNK,
  parameter int NUMWRDS = mem_pkg::DEF_NUMWRDS
);
  import mem_pkg::*;

  localparam int BITVBNK = $clog2(NUMVBNK);
  localparam int BITWRDS = $clog2(NUMWRDS);
  localparam int NUMSROW = NUMADDR / (NUMVBNK * NUMWRDS);
  localparam int BITSROW = $clog2(NUMSROW);

  mem_op_e            op;
  logic [BITVBNK-1:0] bank;
  logic [BITSROW-1:0] row;
  logic [BITWRDS-1:0] word; // word slot inside the row.
  logic [WIDTH-1:0]   din;

  modport ctrl (output op, bank, row, word, din);
  modport array (input op, bank, row, word, din);
  modport tap (input op, bank, row, word, din); // read tracking only.

endinterface

`default_nettype wire

//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // default geometry of the 1rw1w memory.
  localparam int DEF_WIDTH      = 32;   // logical word width.
  localparam int DEF_NUMADDR    = 1024; // logical addresses.
  localparam int DEF_NUMVBNK    = 4;    // sram banks.
  localparam int DEF_NUMWRDS    = 2;    // logical words per physical row.
  localparam int DEF_SRAM_DELAY = 2;    // sram read latency in cycles.

  // operation carried on a bank port request.
  typedef enum logic [1:0] {
    OP_IDLE,
    OP_READ,
    OP_WRITE
  } mem_op_e;

  // init sweep state.
  typedef enum logic {
    INIT_CLEAR, // rows are being zeroed.
    INIT_DONE
  } init_state_e;

endpackage

`default_nettype wire
